//--- all.f
+incdir+rtl
rtl/link_pkg.sv
rtl/chunk_distributor.sv
rtl/deserializer.sv
rtl/word_collector.sv
rtl/lane_deserializer_top.sv
verification/tb_lane_deserializer.sv

//--- rtl/chunk_distributor.sv
`timescale 1ns/1ps
`include "link_config.svh"

module chunk_distributor (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             in_v,
  input  link_pkg::chunk_t                 in_d,
  output logic                             in_a,
  output logic [`LINK_NUM_LANES-1:0]       lane_in_v,
  output link_pkg::chunk_t                 lane_in_d,
  input  logic [`LINK_NUM_LANES-1:0]       lane_in_a,
  input  logic [`LINK_NUM_LANES-1:0]       lane_chunk_last
);

  import link_pkg::*;

  lane_idx_t lane_ptr; // lane currently being filled
  logic      word_done;

  // valid only goes to the selected lane
  always_comb begin
    for (int i = 0; i < `LINK_NUM_LANES; i++) begin
      lane_in_v[i] = in_v && (lane_ptr == lane_idx_t'(i));
    end
  end

  assign lane_in_d = in_d; // data fans out to every lane
  assign in_a      = lane_in_a[lane_ptr];

  // the lane does the chunk counting, we only watch its last flag
  assign word_done = in_v && in_a && lane_chunk_last[lane_ptr];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      lane_ptr <= '0;
    end else if (word_done) begin
      if (lane_ptr == lane_idx_t'(`LINK_NUM_LANES - 1)) begin
        lane_ptr <= '0;
      end else begin
        lane_ptr <= lane_ptr + 1'b1;
      end
    end
  end

  // never offer a chunk to two lanes at once
  a_one_lane_valid: assert property (
    @(posedge clk) disable iff (reset)
    $onehot0(lane_in_v)
  ) else $error("chunk_distributor: more than one lane_in_v high");

  // a lane ack without its valid would desync the word count
  a_ack_needs_valid: assert property (
    @(posedge clk) disable iff (reset)
    in_a |-> in_v
  ) else $error("chunk_distributor: in_a high while in_v low");

endmodule

//--- rtl/deserializer.sv
`timescale 1ns/1ps
`include "link_config.svh"

module deserializer (
  input  logic             clk,
  input  logic             reset,
  input  logic             in_v,
  input  link_pkg::chunk_t in_d,
  output logic             in_a,
  output logic             chunk_last,
  output logic             out_v,
  output link_pkg::word_t  out_d,
  input  logic             out_a
);

  import link_pkg::*;

  typedef enum logic {
    LATCHING,
    SENDING
  } state_t;

  state_t     state;
  chunk_idx_t chunk_idx; // next slot to fill

  // slot 0 holds the first (least significant) chunk
  chunk_t [CHUNKS_PER_WORD-1:0]                      chunks;
  logic   [CHUNKS_PER_WORD*`LINK_CHUNK_WIDTH-1:0]    packed_bits;

  // accept freely while latching
  assign in_a       = (state == LATCHING) && in_v;
  assign chunk_last = in_a && (chunk_idx == chunk_idx_t'(CHUNKS_PER_WORD - 1));

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= LATCHING;
      chunk_idx <= '0;
    end else begin
      case (state)
        LATCHING: begin
          if (chunk_last) begin
            state     <= SENDING;
            chunk_idx <= '0;
          end else if (in_a) begin
            chunk_idx <= chunk_idx + 1'b1;
          end
        end
        SENDING: begin
          if (out_a) begin
            state <= LATCHING; // next word starts one cycle after the ack
          end
        end
        default: begin
          state <= LATCHING;
        end
      endcase
    end
  end

  // payload storage
  always_ff @(posedge clk) begin
    for (int i = 0; i < CHUNKS_PER_WORD; i++) begin
      if (in_a && (chunk_idx == chunk_idx_t'(i))) begin
        chunks[i] <= in_d;
      end
    end
  end

  assign packed_bits = chunks;
  assign out_v       = (state == SENDING);
  assign out_d       = packed_bits[`LINK_WORD_WIDTH-1:0]; // surplus top bits dropped

  // a stalled word must not change under the collector
  a_hold_word: assert property (
    @(posedge clk) disable iff (reset)
    (out_v && !out_a) |=> (out_v && $stable(out_d))
  ) else $error("deserializer: output changed while stalled");

  // no new chunk may land while a finished word waits
  a_no_accept_while_sending: assert property (
    @(posedge clk) disable iff (reset)
    out_v |-> !in_a
  ) else $error("deserializer: chunk accepted while sending");

endmodule

//--- rtl/lane_deserializer_top.sv
`timescale 1ns/1ps
`include "link_config.svh"

module lane_deserializer_top (
  input  logic             clk,
  input  logic             reset,
  input  logic             in_v,
  input  link_pkg::chunk_t in_d,
  output logic             in_a,
  output logic             out_v,
  output link_pkg::word_t  out_d,
  input  logic             out_a
);

  import link_pkg::*;

  // distributor to lanes
  logic [`LINK_NUM_LANES-1:0] lane_in_v;
  chunk_t                     lane_in_d; // shared by all lanes
  logic [`LINK_NUM_LANES-1:0] lane_in_a;
  logic [`LINK_NUM_LANES-1:0] lane_chunk_last;

  // lanes to collector
  logic [`LINK_NUM_LANES-1:0] lane_out_v;
  word_t                      lane_out_d [`LINK_NUM_LANES];
  logic [`LINK_NUM_LANES-1:0] lane_out_a;

  chunk_distributor dist_i (
    .clk             (clk),
    .reset           (reset),
    .in_v            (in_v),
    .in_d            (in_d),
    .in_a            (in_a),
    .lane_in_v       (lane_in_v),
    .lane_in_d       (lane_in_d),
    .lane_in_a       (lane_in_a),
    .lane_chunk_last (lane_chunk_last)
  );

  for (genvar i = 0; i < `LINK_NUM_LANES; i++) begin : lanes
    deserializer deser_i (
      .clk        (clk),
      .reset      (reset),
      .in_v       (lane_in_v[i]),
      .in_d       (lane_in_d),
      .in_a       (lane_in_a[i]),
      .chunk_last (lane_chunk_last[i]),
      .out_v      (lane_out_v[i]),
      .out_d      (lane_out_d[i]),
      .out_a      (lane_out_a[i])
    );
  end

  word_collector coll_i (
    .clk        (clk),
    .reset      (reset),
    .lane_out_v (lane_out_v),
    .lane_out_d (lane_out_d),
    .lane_out_a (lane_out_a),
    .out_v      (out_v),
    .out_d      (out_d),
    .out_a      (out_a)
  );

endmodule

//--- rtl/link_config.svh
`ifndef LINK_CONFIG_SVH
`define LINK_CONFIG_SVH

// width of one chunk on the narrow input channel
`define LINK_CHUNK_WIDTH 8

// assembled word is not a chunk multiple so the top bits get dropped
`define LINK_WORD_WIDTH 28

`define LINK_NUM_LANES 4 // round-robin lanes

`endif

//--- rtl/link_pkg.sv
`include "link_config.svh"

package link_pkg;

  typedef logic [`LINK_CHUNK_WIDTH-1:0] chunk_t;
  typedef logic [`LINK_WORD_WIDTH-1:0] word_t;

  typedef logic [$clog2(`LINK_NUM_LANES)-1:0] lane_idx_t;

  // chunks per word, rounded up
  localparam int CHUNKS_PER_WORD =
    (`LINK_WORD_WIDTH + `LINK_CHUNK_WIDTH - 1) / `LINK_CHUNK_WIDTH;

  typedef logic [$clog2(CHUNKS_PER_WORD)-1:0] chunk_idx_t;

endpackage

//--- rtl/word_collector.sv
`timescale 1ns/1ps
`include "link_config.svh"

module word_collector (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [`LINK_NUM_LANES-1:0] lane_out_v,
  input  link_pkg::word_t            lane_out_d [`LINK_NUM_LANES],
  output logic [`LINK_NUM_LANES-1:0] lane_out_a,
  output logic                       out_v,
  output link_pkg::word_t            out_d,
  input  logic                       out_a
);

  import link_pkg::*;

  lane_idx_t rd_ptr; // lane expected to hold the oldest word
  logic      xfer;

  assign out_v = lane_out_v[rd_ptr];
  assign out_d = lane_out_d[rd_ptr];

  // ack only reaches the lane being read
  always_comb begin
    for (int i = 0; i < `LINK_NUM_LANES; i++) begin
      lane_out_a[i] = out_a && (rd_ptr == lane_idx_t'(i));
    end
  end

  assign xfer = out_v && out_a;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rd_ptr <= '0;
    end else if (xfer) begin
      // same rotation as the distributor, so order is kept
      if (rd_ptr == lane_idx_t'(`LINK_NUM_LANES - 1)) begin
        rd_ptr <= '0;
      end else begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // output word held across back-pressure
  a_out_stable: assert property (
    @(posedge clk) disable iff (reset)
    (out_v && !out_a) |=> $stable(out_d)
  ) else $error("word_collector: out_d changed while stalled");

endmodule

//--- run.sh
#!/bin/sh
# build and run the lane deserializer testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_lane_deserializer -f all.f || exit 1
sim_out=$(./obj_dir/Vtb_lane_deserializer)
echo "$sim_out"
echo "$sim_out" | grep -q "TEST RESULT: PASS" && echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- verification/tb_lane_deserializer.sv
`timescale 1ns/1ps
`include "link_config.svh"

module tb_lane_deserializer;

  import link_pkg::*;

  localparam int NUM_TESTS    = 5;
  localparam int SEED         = 50;
  localparam int RESET_CYCLES = 5;
  localparam int STALL_CYCLES = 12; // how long the blocked input is watched
  localparam int LANE_CHUNKS  = `LINK_NUM_LANES * CHUNKS_PER_WORD; // chunks all lanes can hold
  localparam int RAW_WIDTH    = CHUNKS_PER_WORD * `LINK_CHUNK_WIDTH;

  logic   clk = 1'b0;
  logic   reset;
  logic   in_v;
  chunk_t in_d;
  logic   in_a;
  logic   out_v;
  word_t  out_d;
  logic   out_a;

  // one column per table field, one entry per test
  string       test_name   [NUM_TESTS] = '{"assembly", "input_gaps", "backpressure",
                                           "mid_reset", "mixed"};
  int          test_words  [NUM_TESTS] = '{12, 24, 10, 10, 20};
  int          gap_pct     [NUM_TESTS] = '{0, 40, 0, 0, 25}; // chance of an idle input cycle
  logic [15:0] ready_pat   [NUM_TESTS] = '{16'hffff, 16'hffff, 16'hffff, 16'hffff, 16'hb5c9};
  bit          hold_first  [NUM_TESTS] = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
  bit          reset_first [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0};

  word_t exp_q [$]; // words still owed by the DUT, oldest first
  int    chunks_acc;
  int    error_count = 0;
  int    pass_count = 0;
  int    fail_count = 0;
  int    cycle_count = 0;
  int    cycle_limit;

  lane_deserializer_top dut_i (
    .clk   (clk),
    .reset (reset),
    .in_v  (in_v),
    .in_d  (in_d),
    .in_a  (in_a),
    .out_v (out_v),
    .out_d (out_d),
    .out_a (out_a)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: the stream did not finish within %0d cycles", cycle_limit);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // hold one chunk on the input until the link takes it
  task automatic send_chunk(input chunk_t c);
    logic taken;
    in_v <= 1'b1;
    in_d <= c;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = in_a;
      @(posedge clk);
    end
    chunks_acc++;
  endtask

  task automatic send_stream(input int t);
    logic [RAW_WIDTH-1:0] raw;
    for (int w = 0; w < test_words[t]; w++) begin
      raw = $urandom(); // top nibble is junk in the last chunk
      exp_q.push_back(raw[`LINK_WORD_WIDTH-1:0]);
      for (int k = 0; k < CHUNKS_PER_WORD; k++) begin
        while (int'($urandom_range(99, 0)) < gap_pct[t]) begin
          in_v <= 1'b0;
          @(posedge clk);
        end
        send_chunk(raw[k*`LINK_CHUNK_WIDTH +: `LINK_CHUNK_WIDTH]);
      end
    end
    in_v <= 1'b0;
  endtask

  task automatic drain_stream(input int t);
    logic [3:0] pat_idx;
    int         got;
    word_t      want;
    pat_idx = 4'd0;
    got = 0;
    if (hold_first[t]) begin
      out_a <= 1'b0;
      while (chunks_acc < LANE_CHUNKS) begin
        @(negedge clk);
      end
      // every lane is full, so the input must stay blocked
      repeat (STALL_CYCLES) begin
        @(negedge clk);
        assert (!(in_v && in_a)) else begin
          $display("Fail at %0t: chunk accepted while every lane holds a word", $time);
          error_count++;
        end
        @(posedge clk);
      end
      assert (chunks_acc == LANE_CHUNKS) else begin
        $display("Fail at %0t: %0d chunks taken under back-pressure, expected %0d",
                 $time, chunks_acc, LANE_CHUNKS);
        error_count++;
      end
    end
    while (got < test_words[t]) begin
      out_a <= ready_pat[t][pat_idx];
      pat_idx = pat_idx + 4'd1;
      @(negedge clk);
      if (out_v && out_a) begin
        want = exp_q.pop_front();
        assert (out_d === want) else begin
          $display("Fail at %0t: word %0d expected %h got %h", $time, got, want, out_d);
          error_count++;
        end
        got++;
      end
      @(posedge clk);
    end
    out_a <= 1'b0;
  endtask

  // a finished word waits in its lane and half of the next is in, then reset wipes both
  task automatic reset_mid_word();
    chunk_t c;
    for (int k = 0; k < CHUNKS_PER_WORD + CHUNKS_PER_WORD / 2; k++) begin
      c = chunk_t'($urandom());
      send_chunk(c);
    end
    in_v  <= 1'b0;
    reset <= 1'b1;
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      assert (!out_v) else begin
        $display("Fail at %0t: out_v high during a reset", $time);
        error_count++;
      end
      @(posedge clk);
    end
    reset <= 1'b0;
    @(negedge clk); // first cycle out of reset
    assert (!out_v) else begin
      $display("Fail at %0t: out_v high right after a reset", $time);
      error_count++;
    end
    @(posedge clk);
  endtask

  task automatic run_test(input int t);
    int errs_before;
    errs_before = error_count;
    exp_q.delete();
    if (reset_first[t]) begin
      reset_mid_word();
    end
    chunks_acc = 0;
    fork
      send_stream(t);
      drain_stream(t);
    join
    if (error_count == errs_before) begin
      pass_count++;
      $display("test %s: passed, %0d words", test_name[t], test_words[t]);
    end else begin
      fail_count++;
      $display("test %s: failed with %0d errors", test_name[t], error_count - errs_before);
    end
  endtask

  initial begin
    int total_words;
    total_words = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      total_words += test_words[t];
    end
    cycle_limit = total_words * 4 * 8 + 200;
    void'($urandom(SEED));
    reset <= 1'b1;
    in_v  <= 1'b0;
    in_d  <= '0;
    out_a <= 1'b0;
    repeat (RESET_CYCLES) begin
      @(posedge clk);
    end
    reset <= 1'b0;
    @(posedge clk);
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
